// File: sw_afu_pkg.sv
// Scores are signed 16-bit, so query and database lengths are capped at 8 bits by the control word
`default_nettype none

package sw_afu_pkg;

  // Width of H, E and F values inside the array
  localparam int score_w = 16;

  // Substitution scores
  localparam int match_score    = 2;
  localparam int mismatch_score = -1;

  // Affine gap cost for length k is gap_open + (k - 1) * gap_extend
  localparam int gap_open   = 3;
  localparam int gap_extend = 1;

  // Register word addresses
  localparam logic [1:0] addr_ctrl   = 2'd0;
  localparam logic [1:0] addr_query  = 2'd1;
  localparam logic [1:0] addr_db     = 2'd2;
  localparam logic [1:0] addr_status = 2'd3;

  // Status word fields, the score sits in bits 7:0
  localparam int status_busy_bit = 8;
  localparam int status_done_bit = 9;

  // Control word as seen at addr_ctrl
  typedef struct packed {
    logic [14:0] reserved;
    logic [7:0]  db_len;
    logic [7:0]  query_len;
    logic        start;
  } t_ctrl_fields;

  // One register write, decoded by address as control fields or four characters
  typedef union packed {
    t_ctrl_fields    ctrl;
    logic [3:0][7:0] chars;
  } t_mmio_word;

  // Signed maximum shared by the cells and the result tracker
  function automatic logic signed [score_w-1:0] score_max(input logic signed [score_w-1:0] a,
                                                          input logic signed [score_w-1:0] b);
    return (a > b) ? a : b;
  endfunction

endpackage

`default_nettype wire

// File: sw_stream_if.sv
// Character stream without back-pressure; count and conf are only meaningful while valid is high
`timescale 1ns/1ns
`default_nettype none

interface sw_stream_if;

  // One character per cycle
  logic [7:0] data;

  // Qualifies data, there is no ready in the other direction
  logic       valid;

  // Query length for the current job, held steady while the job runs
  logic [7:0] count;

  // High for query characters and low for database characters
  logic       conf;

  // Requestor side
  modport src (
    output data,
    output valid,
    output count,
    output conf
  );

  // Array side
  modport snk (
    input data,
    input valid,
    input count,
    input conf
  );

endinterface

`default_nettype wire

// File: sw_ctrl_if.sv
// Register block to requestor link; lengths are only sampled in the cycle that start is high
`timescale 1ns/1ns
`default_nettype none

interface sw_ctrl_if;

  // Job launch, one-cycle pulse with the lengths alongside
  logic            start;
  logic [7:0]      query_len;
  logic [7:0]      db_len;

  // Buffer appends of four characters, lowest byte first
  logic            wr_query;
  logic            wr_db;
  logic [3:0][7:0] wr_chars;

  // Job state and result coming back
  logic            busy;
  logic            done;
  logic [7:0]      score;

  modport csr (
    output start,
    output query_len,
    output db_len,
    output wr_query,
    output wr_db,
    output wr_chars,
    input  busy,
    input  done,
    input  score
  );

  modport req (
    input  start,
    input  query_len,
    input  db_len,
    input  wr_query,
    input  wr_db,
    input  wr_chars,
    output busy,
    output done,
    output score
  );

endinterface

`default_nettype wire

// File: sw_csr.sv
// Reads return data one cycle after mmio_rd; only addr_status reads back, other addresses read as zero
`timescale 1ns/1ns
`default_nettype none

module sw_csr
  import sw_afu_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         mmio_wr,
  input  wire         mmio_rd,
  input  wire  [1:0]  mmio_addr,
  input  wire  [31:0] mmio_wdata,
  output logic [31:0] mmio_rdata,
  output logic        mmio_rvalid,
  sw_ctrl_if.csr      ctrl
);

  t_mmio_word  wword;
  logic        done_flag;
  logic [7:0]  score_q;
  logic [31:0] status;

  // The same write word is viewed as control fields or as characters
  assign wword = mmio_wdata;

  // Start only reaches the requestor when it is idle
  assign ctrl.start     = mmio_wr && (mmio_addr == addr_ctrl) && wword.ctrl.start && !ctrl.busy;
  assign ctrl.query_len = wword.ctrl.query_len;
  assign ctrl.db_len    = wword.ctrl.db_len;

  // Character writes go straight through to the buffers
  assign ctrl.wr_query = mmio_wr && (mmio_addr == addr_query);
  assign ctrl.wr_db    = mmio_wr && (mmio_addr == addr_db);
  assign ctrl.wr_chars = wword.chars;

  // Busy is taken live from the requestor
  always_comb begin
    status                  = '0;
    status[status_done_bit] = done_flag;
    status[status_busy_bit] = ctrl.busy;
    status[7:0]             = score_q;
  end

  // Done stays set until the next accepted start
  always_ff @(posedge clk) begin
    if (rst) begin
      done_flag   <= 1'b0;
      score_q     <= '0;
      mmio_rvalid <= 1'b0;
    end else begin
      mmio_rvalid <= mmio_rd;
      if (ctrl.start) begin
        done_flag <= 1'b0;
      end else if (ctrl.done) begin
        done_flag <= 1'b1;
        score_q   <= ctrl.score;
      end
    end
  end

  // Read data is captured with the strobe
  always_ff @(posedge clk) begin
    if (mmio_rd) begin
      mmio_rdata <= (mmio_addr == addr_status) ? status : '0;
    end
  end

endmodule

`default_nettype wire

// File: sw_requestor.sv
// Writes past a full buffer are dropped; buffers must not be written while a job is running
`timescale 1ns/1ns
`default_nettype none

module sw_requestor #(
  parameter int num_pe    = 8,
  parameter int buf_depth = 64
) (
  input  wire        clk,
  input  wire        rst,
  sw_ctrl_if.req     ctrl,
  sw_stream_if.src   stream,
  input  wire  [7:0] score_data,
  input  wire        score_valid
);

  localparam int q_aw = $clog2(num_pe);
  localparam int d_aw = $clog2(buf_depth);

  localparam logic [1:0] s_idle  = 2'd0;
  localparam logic [1:0] s_query = 2'd1;
  localparam logic [1:0] s_db    = 2'd2;
  localparam logic [1:0] s_wait  = 2'd3;

  logic [7:0] query_buf [num_pe];
  logic [7:0] db_buf    [buf_depth];
  logic [7:0] q_wptr;
  logic [7:0] d_wptr;
  logic [1:0] state;
  logic [7:0] q_len;
  logic [7:0] d_len;
  logic [7:0] rd_idx;
  logic [7:0] score;
  logic       busy;
  logic       done;
  logic       valid;
  logic       conf;

  // Each write appends four characters starting at the write pointer
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (ctrl.wr_query && (q_wptr + 8'(i) < 8'(num_pe))) begin
        query_buf[q_aw'(q_wptr + 8'(i))] <= ctrl.wr_chars[i];
      end
      if (ctrl.wr_db && (d_wptr + 8'(i) < 8'(buf_depth))) begin
        db_buf[d_aw'(d_wptr + 8'(i))] <= ctrl.wr_chars[i];
      end
    end
  end

  // Job FSM: query characters, then database characters, then wait for the score
  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= s_idle;
      q_wptr <= '0;
      d_wptr <= '0;
      q_len  <= '0;
      d_len  <= '0;
      rd_idx <= '0;
      score  <= '0;
      busy   <= 1'b0;
      done   <= 1'b0;
      valid  <= 1'b0;
      conf   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (ctrl.wr_query && (q_wptr < 8'(num_pe))) begin
        q_wptr <= q_wptr + 8'd4;
      end
      if (ctrl.wr_db && (d_wptr < 8'(buf_depth))) begin
        d_wptr <= d_wptr + 8'd4;
      end
      case (state)
        s_idle: begin
          // First query character goes out in the cycle after start
          if (ctrl.start) begin
            q_len  <= ctrl.query_len;
            d_len  <= ctrl.db_len;
            rd_idx <= '0;
            busy   <= 1'b1;
            valid  <= 1'b1;
            conf   <= 1'b1;
            state  <= s_query;
          end
        end
        s_query: begin
          // Database phase follows with no idle cycle
          if (rd_idx == q_len - 8'd1) begin
            rd_idx <= '0;
            conf   <= 1'b0;
            state  <= s_db;
          end else begin
            rd_idx <= rd_idx + 8'd1;
          end
        end
        s_db: begin
          if (rd_idx == d_len - 8'd1) begin
            valid <= 1'b0;
            state <= s_wait;
          end else begin
            rd_idx <= rd_idx + 8'd1;
          end
        end
        s_wait: begin
          // Buffers are rewound so the next job loads from the start
          if (score_valid) begin
            score  <= score_data;
            busy   <= 1'b0;
            done   <= 1'b1;
            q_wptr <= '0;
            d_wptr <= '0;
            state  <= s_idle;
          end
        end
      endcase
    end
  end

  assign stream.data  = conf ? query_buf[q_aw'(rd_idx)] : db_buf[d_aw'(rd_idx)];
  assign stream.valid = valid;
  assign stream.conf  = conf;
  assign stream.count = q_len;

  assign ctrl.busy  = busy;
  assign ctrl.done  = done;
  assign ctrl.score = score;

endmodule

`default_nettype wire

// File: sw_pe_affine.sv
// One Gotoh cell column; its state is cleared by every load strobe, so each job must reload the query
`timescale 1ns/1ns
`default_nettype none

module sw_pe_affine
  import sw_afu_pkg::*;
(
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       load_in,
  input  wire  [7:0]                load_char_in,
  output logic                      load_out,
  output logic [7:0]                load_char_out,
  input  wire                       active,
  input  wire                       db_valid_in,
  input  wire  [7:0]                db_char_in,
  input  wire  signed [score_w-1:0] h_left_in,
  input  wire  signed [score_w-1:0] f_left_in,
  input  wire  signed [score_w-1:0] max_in,
  output logic                      db_valid_out,
  output logic [7:0]                db_char_out,
  output logic signed [score_w-1:0] h_out,
  output logic signed [score_w-1:0] f_out,
  output logic signed [score_w-1:0] max_out
);

  logic [7:0]                q_char;
  logic signed [score_w-1:0] h_up;
  logic signed [score_w-1:0] e_up;
  logic signed [score_w-1:0] h_diag;
  logic signed [score_w-1:0] subst;
  logic signed [score_w-1:0] e_new;
  logic signed [score_w-1:0] f_new;
  logic signed [score_w-1:0] h_new;

  // Load strobe is shared by the whole chain so all cells shift together
  assign load_out      = load_in;
  assign load_char_out = q_char;

  // E runs down this column and F runs along the row from the left neighbour
  always_comb begin
    subst = (db_char_in == q_char) ? score_w'(match_score) : score_w'(mismatch_score);
    e_new = score_max(h_up - score_w'(gap_open), e_up - score_w'(gap_extend));
    f_new = score_max(h_left_in - score_w'(gap_open), f_left_in - score_w'(gap_extend));
    h_new = score_max(score_max(h_diag + subst, '0), score_max(e_new, f_new));
  end

  always_ff @(posedge clk) begin
    if (load_in) begin
      q_char <= load_char_in;
    end
  end

  // Row above starts at zero for every new job
  always_ff @(posedge clk) begin
    if (rst) begin
      db_valid_out <= 1'b0;
      h_up         <= '0;
      e_up         <= '0;
      h_diag       <= '0;
    end else begin
      db_valid_out <= db_valid_in;
      if (load_in) begin
        h_up   <= '0;
        e_up   <= '0;
        h_diag <= '0;
      end else if (active && db_valid_in) begin
        h_up   <= h_new;
        e_up   <= e_new;
        h_diag <= h_left_in;
      end
    end
  end

  // An idle cell only adds one cycle of delay to the row values
  always_ff @(posedge clk) begin
    db_char_out <= db_char_in;
    if (active) begin
      h_out   <= h_new;
      f_out   <= f_new;
      max_out <= score_max(max_in, h_new);
    end else begin
      h_out   <= h_left_in;
      f_out   <= f_left_in;
      max_out <= max_in;
    end
  end

endmodule

`default_nettype wire

// File: sw_top_affine.sv
// Query length must be 1 to num_pe; the score byte is the low 8 bits of the best cell value
`timescale 1ns/1ns
`default_nettype none

module sw_top_affine
  import sw_afu_pkg::*;
#(
  parameter int num_pe = 8
) (
  input  wire        clk,
  input  wire        rst,
  sw_stream_if.snk   stream,
  output logic [7:0] score_data,
  output logic       score_valid
);

  // Load chain runs from the last cell down to cell 0
  logic                      load_c [num_pe+1];
  logic [7:0]                char_c [num_pe+1];
  logic                      active [num_pe];

  // Database chain runs from cell 0 upwards
  logic                      dv [num_pe+1];
  logic [7:0]                dc [num_pe+1];
  logic signed [score_w-1:0] hc [num_pe+1];
  logic signed [score_w-1:0] fc [num_pe+1];
  logic signed [score_w-1:0] mc [num_pe+1];

  logic signed [score_w-1:0] best;
  logic                      tail_q;
  logic                      tail_end;

  // Query characters enter at the far end, so the first one settles in the lowest active cell
  assign load_c[num_pe] = stream.valid && stream.conf;
  assign char_c[num_pe] = stream.data;

  // Database characters enter cell 0 with a zero left boundary
  assign dv[0] = stream.valid && !stream.conf;
  assign dc[0] = stream.data;
  assign hc[0] = '0;
  assign fc[0] = '0;
  assign mc[0] = '0;

  for (genvar i = 0; i < num_pe; i++) begin : g_pe
    // The count cells nearest the load entry hold the query
    assign active[i] = stream.count > 8'(num_pe - 1 - i);

    sw_pe_affine i_pe (
      .clk           (clk),
      .rst           (rst),
      .load_in       (load_c[i+1]),
      .load_char_in  (char_c[i+1]),
      .load_out      (load_c[i]),
      .load_char_out (char_c[i]),
      .active        (active[i]),
      .db_valid_in   (dv[i]),
      .db_char_in    (dc[i]),
      .h_left_in     (hc[i]),
      .f_left_in     (fc[i]),
      .max_in        (mc[i]),
      .db_valid_out  (dv[i+1]),
      .db_char_out   (dc[i+1]),
      .h_out         (hc[i+1]),
      .f_out         (fc[i+1]),
      .max_out       (mc[i+1])
    );
  end

  // Falling edge of the chain's valid marks the last row leaving the array
  assign tail_end = tail_q && !dv[num_pe];

  // Each row maximum from the last cell folds into the job maximum
  always_ff @(posedge clk) begin
    if (rst) begin
      tail_q      <= 1'b0;
      score_valid <= 1'b0;
      best        <= '0;
    end else begin
      tail_q      <= dv[num_pe];
      score_valid <= tail_end;
      if (load_c[0]) begin
        best <= '0;
      end else if (dv[num_pe]) begin
        best <= score_max(best, mc[num_pe]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tail_end) begin
      score_data <= best[7:0];
    end
  end

endmodule

`default_nettype wire

// File: sw_afu.sv
// Single clock domain with a plain register strobe port; query and database lengths are bounded by the parameters
`timescale 1ns/1ns
`default_nettype none

module sw_afu #(
  parameter int num_pe    = 8,
  parameter int buf_depth = 64
) (
  input  wire         clk,
  input  wire         rst,
  input  wire         mmio_wr,
  input  wire         mmio_rd,
  input  wire  [1:0]  mmio_addr,
  input  wire  [31:0] mmio_wdata,
  output logic [31:0] mmio_rdata,
  output logic        mmio_rvalid
);

  // Result byte coming back from the array
  logic [7:0] score_data;
  logic       score_valid;

  sw_ctrl_if   ctrl ();
  sw_stream_if stream ();

  sw_csr i_sw_csr (
    .clk         (clk),
    .rst         (rst),
    .mmio_wr     (mmio_wr),
    .mmio_rd     (mmio_rd),
    .mmio_addr   (mmio_addr),
    .mmio_wdata  (mmio_wdata),
    .mmio_rdata  (mmio_rdata),
    .mmio_rvalid (mmio_rvalid),
    .ctrl        (ctrl)
  );

  sw_requestor #(
    .num_pe    (num_pe),
    .buf_depth (buf_depth)
  ) i_sw_requestor (
    .clk         (clk),
    .rst         (rst),
    .ctrl        (ctrl),
    .stream      (stream),
    .score_data  (score_data),
    .score_valid (score_valid)
  );

  sw_top_affine #(
    .num_pe (num_pe)
  ) i_sw_top_affine (
    .clk         (clk),
    .rst         (rst),
    .stream      (stream),
    .score_data  (score_data),
    .score_valid (score_valid)
  );

endmodule

`default_nettype wire

// File: sw_afu_properties.sv
// Bound into sw_requestor; the simulator must have concurrent assertions enabled
`timescale 1ns/1ns
`default_nettype none

module sw_afu_properties (
  input wire clk,
  input wire rst,
  input wire busy,
  input wire valid,
  input wire conf,
  input wire score_valid,
  input wire done
);

  // Number of failed properties so far
  int violations = 0;

  // No character leaves the requestor outside a job
  valid_needs_busy: assert property (@(posedge clk) disable iff (rst) valid |-> busy)
    else begin
      $error("stream valid is high while the requestor is not busy");
      violations++;
    end

  // Query phase only begins from idle, so conf cannot come back once database bytes flow
  conf_once_per_job: assert property (@(posedge clk) disable iff (rst) $rose(conf) |-> !$past(busy))
    else begin
      $error("conf rose again inside a running job");
      violations++;
    end

  // The score handshake closes the job in the next cycle
  done_after_score: assert property (@(posedge clk) disable iff (rst) score_valid |=> done)
    else begin
      $error("done did not follow score_valid by one cycle");
      violations++;
    end

endmodule

`default_nettype wire

// File: tb_sw_afu.sv
// Built for num_pe 8 and buf_depth 64; needs a simulator with timing and immediate assertions enabled
`timescale 1ns/1ns
`default_nettype none

module tb_sw_afu
  import sw_afu_pkg::*;
();

  localparam int num_pe         = 8;
  localparam int buf_depth      = 64;
  localparam int clk_period     = 40;
  localparam int timeout_cycles = 40 * (num_pe + buf_depth + 40);

  logic        clk = 1'b0;
  logic        rst;
  logic        mmio_wr;
  logic        mmio_rd;
  logic [1:0]  mmio_addr;
  logic [31:0] mmio_wdata;
  logic [31:0] mmio_rdata;
  logic        mmio_rvalid;

  // Stimulus state and the sequences of the current job
  logic [31:0] lfsr;
  logic [7:0]  q_seq [num_pe];
  logic [7:0]  d_seq [buf_depth];
  int          cycles = 0;
  int          errors = 0;
  int          errors_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  sw_afu #(
    .num_pe    (num_pe),
    .buf_depth (buf_depth)
  ) i_sw_afu (
    .clk         (clk),
    .rst         (rst),
    .mmio_wr     (mmio_wr),
    .mmio_rd     (mmio_rd),
    .mmio_addr   (mmio_addr),
    .mmio_wdata  (mmio_wdata),
    .mmio_rdata  (mmio_rdata),
    .mmio_rvalid (mmio_rvalid)
  );

  bind sw_requestor sw_afu_properties i_sw_afu_properties (
    .clk         (clk),
    .rst         (rst),
    .busy        (busy),
    .valid       (valid),
    .conf        (conf),
    .score_valid (score_valid),
    .done        (done)
  );

  always #(clk_period / 2) clk = ~clk;

  // Watchdog sized for 40 of the longest jobs
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles, the DUT never reported done", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // Right-shifting Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit with the bits collected MSB first
  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = (value << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic logic [7:0] base_char(input int code);
    case (code)
      0:       return 8'h41;
      1:       return 8'h43;
      2:       return 8'h47;
      default: return 8'h54;
    endcase
  endfunction

  task automatic fill_random(input int qlen, input int dlen);
    int r;
    for (int j = 0; j < qlen; j++) begin
      take_bits(2, r);
      q_seq[j] = base_char(r);
    end
    for (int j = 0; j < dlen; j++) begin
      take_bits(2, r);
      d_seq[j] = base_char(r);
    end
  endtask

  function automatic int max2(input int a, input int b);
    return (a > b) ? a : b;
  endfunction

  // Gotoh recurrence with database characters as rows and query characters as columns
  task automatic gotoh_model(input int qlen, input int dlen, output int best);
    int h_prev [num_pe+1];
    int e_prev [num_pe+1];
    int h_row  [num_pe+1];
    int e_new;
    int f_cur;
    int diag;
    best = 0;
    for (int j = 0; j <= num_pe; j++) begin
      h_prev[j] = 0;
      e_prev[j] = -1000;
    end
    for (int i = 0; i < dlen; i++) begin
      h_row[0] = 0;
      f_cur    = -1000;
      for (int j = 1; j <= qlen; j++) begin
        e_new     = max2(h_prev[j] - gap_open, e_prev[j] - gap_extend);
        f_cur     = max2(h_row[j-1] - gap_open, f_cur - gap_extend);
        diag      = h_prev[j-1] + ((d_seq[i] == q_seq[j-1]) ? match_score : mismatch_score);
        h_row[j]  = max2(max2(0, diag), max2(e_new, f_cur));
        e_prev[j] = e_new;
        best      = max2(best, h_row[j]);
      end
      for (int j = 1; j <= qlen; j++) begin
        h_prev[j] = h_row[j];
      end
    end
  endtask

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // Register tasks are entered just after a falling edge and return on one
  task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
    mmio_wr    = 1'b1;
    mmio_addr  = addr;
    mmio_wdata = data;
    @(negedge clk);
    mmio_wr = 1'b0;
  endtask

  task automatic read_status(output logic [31:0] data);
    mmio_rd   = 1'b1;
    mmio_addr = addr_status;
    @(negedge clk);
    mmio_rd = 1'b0;
    check_hex("mmio_rvalid", 32'(mmio_rvalid), 32'h1);
    data = mmio_rdata;
  endtask

  // Four characters go in each word with the lowest byte first
  task automatic load_buffers(input int qlen, input int dlen);
    t_mmio_word w;
    for (int b = 0; b < qlen; b += 4) begin
      for (int k = 0; k < 4; k++) begin
        w.chars[k] = (b + k < qlen) ? q_seq[b + k] : 8'h00;
      end
      write_reg(addr_query, w);
    end
    for (int b = 0; b < dlen; b += 4) begin
      for (int k = 0; k < 4; k++) begin
        w.chars[k] = (b + k < dlen) ? d_seq[b + k] : 8'h00;
      end
      write_reg(addr_db, w);
    end
  endtask

  task automatic start_job(input int qlen, input int dlen);
    t_mmio_word w;
    w                = '0;
    w.ctrl.start     = 1'b1;
    w.ctrl.query_len = 8'(qlen);
    w.ctrl.db_len    = 8'(dlen);
    write_reg(addr_ctrl, w);
  endtask

  task automatic wait_done(output logic [31:0] status);
    status = '0;
    while (!status[status_done_bit]) begin
      read_status(status);
    end
  endtask

  task automatic run_and_check(input int qlen, input int dlen, output int got);
    logic [31:0] status;
    int          expected;
    load_buffers(qlen, dlen);
    start_job(qlen, dlen);
    wait_done(status);
    gotoh_model(qlen, dlen, expected);
    check_hex("status.busy", 32'(status[status_busy_bit]), 32'h0);
    check_hex("score", 32'(status[7:0]), 32'(expected));
    got = int'(status[7:0]);
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("Test %s failed", name);
    end else begin
      $display("Test %s passed", name);
    end
    errors_at_start = errors;
  endtask

  initial begin
    logic [31:0] status;
    int          qlen;
    int          dlen;
    int          r;
    int          got;
    int          expected;
    rst        = 1'b1;
    mmio_wr    = 1'b0;
    mmio_rd    = 1'b0;
    mmio_addr  = '0;
    mmio_wdata = '0;
    lfsr       = 32'h92b;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // Idle status and the one-cycle read pulse
    check_hex("mmio_rvalid", 32'(mmio_rvalid), 32'h0);
    read_status(status);
    check_hex("status", status, 32'h0);
    @(negedge clk);
    check_hex("mmio_rvalid", 32'(mmio_rvalid), 32'h0);
    report_test("reset_status");

    // Identical sequences align along the full diagonal
    take_bits(8, r);
    qlen = r % num_pe + 1;
    fill_random(qlen, 0);
    for (int j = 0; j < qlen; j++) begin
      d_seq[j] = q_seq[j];
    end
    run_and_check(qlen, qlen, got);
    check_hex("score", 32'(got), 32'(match_score * qlen));
    report_test("identical");

    // Even jobs use queries shorter than the array
    for (int k = 0; k < 30; k++) begin
      take_bits(8, r);
      qlen = (k % 2 == 0) ? r % (num_pe - 1) + 1 : r % num_pe + 1;
      take_bits(8, r);
      dlen = r % buf_depth + 1;
      fill_random(qlen, dlen);
      run_and_check(qlen, dlen, got);
    end
    report_test("random_jobs");

    // Database is the query with three N characters inserted in the middle
    fill_random(num_pe, 0);
    for (int j = 0; j < num_pe + 3; j++) begin
      if (j < num_pe / 2) begin
        d_seq[j] = q_seq[j];
      end else if (j < num_pe / 2 + 3) begin
        d_seq[j] = 8'h4e;
      end else begin
        d_seq[j] = q_seq[j - 3];
      end
    end
    expected = match_score * num_pe - gap_open - 2 * gap_extend;
    gotoh_model(num_pe, num_pe + 3, r);
    check_hex("model_score", 32'(r), 32'(expected));
    run_and_check(num_pe, num_pe + 3, got);
    check_hex("score", 32'(got), 32'(expected));
    // Charging gap_open for every inserted character would be the linear cost
    assert (got != match_score * num_pe - 3 * gap_open) else begin
      $display("Score %0d is what a linear gap cost gives for the insertion", got);
      errors++;
    end
    report_test("affine_gap");

    // A second start while busy must not disturb the running job
    take_bits(8, r);
    qlen = r % num_pe + 1;
    take_bits(8, r);
    dlen = buf_depth / 2 + r % (buf_depth / 2) + 1;
    fill_random(qlen, dlen);
    load_buffers(qlen, dlen);
    gotoh_model(qlen, dlen, expected);
    start_job(qlen, dlen);
    start_job(1, 1);
    read_status(status);
    check_hex("status.busy", 32'(status[status_busy_bit]), 32'h1);
    wait_done(status);
    check_hex("status.busy", 32'(status[status_busy_bit]), 32'h0);
    check_hex("score", 32'(status[7:0]), 32'(expected));
    report_test("start_while_busy");

    $display("Tests run %0d, tests failed %0d, failed checks %0d, property failures %0d",
             tests_run, tests_failed, errors,
             i_sw_afu.i_sw_requestor.i_sw_afu_properties.violations);
    if (tests_failed == 0 && i_sw_afu.i_sw_requestor.i_sw_afu_properties.violations == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sw_afu.f
sw_afu_pkg.sv
sw_stream_if.sv
sw_ctrl_if.sv
sw_csr.sv
sw_requestor.sv
sw_pe_affine.sv
sw_top_affine.sv
sw_afu.sv
sw_afu_properties.sv
tb_sw_afu.sv

// File: Makefile
# Verilator flow for the Smith-Waterman accelerator testbench

VERILATOR ?= verilator
FILELIST  ?= sw_afu.f
TB_TOP    ?= tb_sw_afu
RTL_TOP   ?= sw_afu
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
